// ==== src/cpu_isa_pkg.sv ====
`default_nettype none

package cpu_isa_pkg;

  // one machine word: data, address and instruction
  typedef logic [15:0] word_t;

  // register index, eight registers
  typedef logic [2:0] reg_addr_t;

  // raw immediate field before sign extension
  typedef logic [7:0] imm8_t;

  // width of the full opcode field, immediate flag included
  localparam int OPCODE_W = 5;

  // immediate form selector inside the opcode field
  localparam int IMM_BIT = 4;

  // field positions in the instruction word
  localparam int RX_LSB = 5;
  localparam int RY_LSB = 8;
  localparam int IMM_LSB = 8;

  // operation codes, the low four bits of the opcode field
  typedef enum logic [3:0] {
    op_mv   = 4'd0,
    op_add  = 4'd1,
    op_sub  = 4'd2,
    op_cmp  = 4'd3,
    op_ld   = 4'd4,
    op_st   = 4'd5,
    op_j    = 4'd8,
    op_jz   = 4'd9,
    op_jn   = 4'd10,
    op_halt = 4'd15
  } opcode_t;

endpackage

`default_nettype wire

// ==== src/cpu_ctrl_pkg.sv ====
`default_nettype none

package cpu_ctrl_pkg;

  // controller phases
  typedef enum logic [2:0] {
    s_fetch,
    s_decode,
    s_execute,
    s_mem,
    s_halt
  } state_t;

  // alu function select
  typedef enum logic [1:0] {
    alu_pass,
    alu_add,
    alu_sub
  } alu_op_t;

  // register writeback source
  typedef enum logic {
    wb_alu,
    wb_mem
  } wb_sel_t;

  // memory address source
  typedef enum logic {
    addr_pc,
    addr_ry
  } addr_sel_t;

  // first fetch address
  localparam cpu_isa_pkg::word_t RESET_PC = '0;

endpackage

`default_nettype wire

// ==== src/cpu_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_control (
  input  logic                                 i_clk,
  input  logic                                 i_reset,
  input  logic [cpu_isa_pkg::OPCODE_W-1:0]     i_opcode,
  input  logic                                 i_flag_n,
  input  logic                                 i_flag_z,
  output logic                                 o_mem_rd,
  output logic                                 o_mem_wr,
  output cpu_ctrl_pkg::addr_sel_t              o_addr_sel,
  output logic                                 o_pc_inc,
  output logic                                 o_pc_ld,
  output logic                                 o_ir_ld,
  output logic                                 o_rf_write,
  output cpu_ctrl_pkg::wb_sel_t                o_wb_sel,
  output cpu_ctrl_pkg::alu_op_t                o_alu_op,
  output logic                                 o_alu_imm_sel,
  output logic                                 o_flag_ld,
  output logic                                 o_halted
);

  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;

  state_t  state;
  state_t  state_nxt;
  opcode_t op;
  logic    imm_form;
  logic    take_jump;
  logic    running;

  assign op = opcode_t'(i_opcode[IMM_BIT-1:0]);
  assign imm_form = i_opcode[IMM_BIT];

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      state <= s_fetch;
      running <= 1'b0;
    end else begin
      state <= state_nxt;
      running <= 1'b1;
    end
  end

  // branch condition from the registered flags
  always_comb begin
    case (op)
      op_j:    take_jump = 1'b1;
      op_jz:   take_jump = i_flag_z;
      op_jn:   take_jump = i_flag_n;
      default: take_jump = 1'b0;
    endcase
  end

  always_comb begin
    state_nxt = state;
    o_mem_rd = 1'b0;
    o_mem_wr = 1'b0;
    o_addr_sel = addr_pc;
    o_pc_inc = 1'b0;
    o_pc_ld = 1'b0;
    o_ir_ld = 1'b0;
    o_rf_write = 1'b0;
    o_wb_sel = wb_alu;
    o_alu_op = alu_pass;
    o_alu_imm_sel = 1'b0;
    o_flag_ld = 1'b0;

    case (state)
      s_fetch: begin
        // idle for the first edge after reset so no strobe shows during reset
        if (running) begin
          o_mem_rd = 1'b1;
          o_pc_inc = 1'b1;
          state_nxt = s_decode;
        end
      end
      s_decode: begin
        o_ir_ld = 1'b1;
        state_nxt = s_execute;
      end
      s_execute: begin
        state_nxt = s_fetch;
        // immediate bit picks operand b and the jump target form
        o_alu_imm_sel = imm_form;
        case (op)
          op_mv: begin
            o_rf_write = 1'b1;
          end
          op_add: begin
            o_alu_op = alu_add;
            o_rf_write = 1'b1;
            o_flag_ld = 1'b1;
          end
          op_sub: begin
            o_alu_op = alu_sub;
            o_rf_write = 1'b1;
            o_flag_ld = 1'b1;
          end
          op_cmp: begin
            o_alu_op = alu_sub;
            o_flag_ld = 1'b1;
          end
          op_ld: begin
            o_mem_rd = 1'b1;
            o_addr_sel = addr_ry;
            state_nxt = s_mem;
          end
          op_st: begin
            o_mem_wr = 1'b1;
            o_addr_sel = addr_ry;
          end
          op_j, op_jz, op_jn: begin
            o_pc_ld = take_jump;
          end
          op_halt: begin
            state_nxt = s_halt;
          end
          // unknown opcodes fall through as no-ops
          default: ;
        endcase
      end
      s_mem: begin
        // load data arrives one cycle after the read strobe
        o_rf_write = 1'b1;
        o_wb_sel = wb_mem;
        state_nxt = s_fetch;
      end
      s_halt: ;
      default: state_nxt = s_fetch;
    endcase
  end

  assign o_halted = (state == s_halt);

endmodule

`default_nettype wire

// ==== src/cpu_pc.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_pc (
  input  logic                i_clk,
  input  logic                i_reset,
  input  logic                i_inc,
  input  logic                i_ld,
  input  cpu_isa_pkg::word_t  i_target,
  output cpu_isa_pkg::word_t  o_pc
);

  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;

  word_t pc;

  // jump load wins over increment
  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      pc <= RESET_PC;
    end else if (i_ld) begin
      pc <= i_target;
    end else if (i_inc) begin
      pc <= pc + word_t'(1);
    end
  end

  assign o_pc = pc;

endmodule

`default_nettype wire

// ==== src/cpu_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  cpu_isa_pkg::reg_addr_t  i_rx_addr,
  input  cpu_isa_pkg::reg_addr_t  i_ry_addr,
  input  logic                    i_write,
  input  cpu_ctrl_pkg::wb_sel_t   i_wb_sel,
  input  cpu_isa_pkg::word_t      i_alu_result,
  input  cpu_isa_pkg::word_t      i_mem_rdata,
  output cpu_isa_pkg::word_t      o_rx_data,
  output cpu_isa_pkg::word_t      o_ry_data
);

  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;

  word_t regs [2**$bits(reg_addr_t)];
  word_t wb_data;

  assign wb_data = (i_wb_sel == wb_mem) ? i_mem_rdata : i_alu_result;

  // destination is always rx
  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      for (int i = 0; i < $size(regs); i++) begin
        regs[i] <= '0;
      end
    end else if (i_write) begin
      regs[i_rx_addr] <= wb_data;
    end
  end

  // asynchronous read ports
  assign o_rx_data = regs[i_rx_addr];
  assign o_ry_data = regs[i_ry_addr];

endmodule

`default_nettype wire

// ==== src/cpu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_alu (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  cpu_ctrl_pkg::alu_op_t  i_op,
  input  logic                   i_imm_sel,
  input  logic                   i_flag_ld,
  input  cpu_isa_pkg::word_t     i_rx_data,
  input  cpu_isa_pkg::word_t     i_ry_data,
  input  cpu_isa_pkg::word_t     i_pc,
  input  cpu_isa_pkg::imm8_t     i_imm,
  output cpu_isa_pkg::word_t     o_result,
  output cpu_isa_pkg::word_t     o_target,
  output logic                   o_flag_n,
  output logic                   o_flag_z
);

  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;

  word_t imm_ext;
  word_t op_b;
  word_t result;

  assign imm_ext = {{($bits(word_t) - $bits(imm8_t)){i_imm[$bits(imm8_t)-1]}}, i_imm};
  assign op_b = i_imm_sel ? imm_ext : i_ry_data;

  always_comb begin
    case (i_op)
      alu_add: result = i_rx_data + op_b;
      alu_sub: result = i_rx_data - op_b;
      default: result = op_b;
    endcase
  end

  assign o_result = result;

  // pc here is already past the jump instruction
  assign o_target = i_imm_sel ? (i_pc + imm_ext) : i_rx_data;

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      o_flag_n <= 1'b0;
      o_flag_z <= 1'b0;
    end else if (i_flag_ld) begin
      o_flag_n <= result[$bits(word_t)-1];
      o_flag_z <= (result == '0);
    end
  end

endmodule

`default_nettype wire

// ==== src/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
  input  logic                i_clk,
  input  logic                i_reset,
  input  cpu_isa_pkg::word_t  i_mem_rdata,
  output cpu_isa_pkg::word_t  o_mem_addr,
  output logic                o_mem_rd,
  output logic                o_mem_wr,
  output cpu_isa_pkg::word_t  o_mem_wdata,
  output logic                o_halted
);

  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;

  word_t     ir;
  reg_addr_t rx_addr;
  reg_addr_t ry_addr;
  imm8_t     imm;

  logic      ir_ld;
  logic      pc_inc;
  logic      pc_ld;
  logic      rf_write;
  logic      alu_imm_sel;
  logic      flag_ld;
  logic      flag_n;
  logic      flag_z;
  addr_sel_t addr_sel;
  wb_sel_t   wb_sel;
  alu_op_t   alu_op;

  word_t     pc;
  word_t     target;
  word_t     alu_result;
  word_t     rx_data;
  word_t     ry_data;

  // instruction register, loaded in decode
  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      ir <= '0;
    end else if (ir_ld) begin
      ir <= i_mem_rdata;
    end
  end

  assign rx_addr = ir[RX_LSB +: $bits(reg_addr_t)];
  assign ry_addr = ir[RY_LSB +: $bits(reg_addr_t)];
  assign imm = ir[IMM_LSB +: $bits(imm8_t)];

  // fetch uses pc, ld and st use ry
  assign o_mem_addr = (addr_sel == addr_ry) ? ry_data : pc;
  assign o_mem_wdata = rx_data;

  cpu_control u_control (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_opcode      (ir[OPCODE_W-1:0]),
    .i_flag_n      (flag_n),
    .i_flag_z      (flag_z),
    .o_mem_rd      (o_mem_rd),
    .o_mem_wr      (o_mem_wr),
    .o_addr_sel    (addr_sel),
    .o_pc_inc      (pc_inc),
    .o_pc_ld       (pc_ld),
    .o_ir_ld       (ir_ld),
    .o_rf_write    (rf_write),
    .o_wb_sel      (wb_sel),
    .o_alu_op      (alu_op),
    .o_alu_imm_sel (alu_imm_sel),
    .o_flag_ld     (flag_ld),
    .o_halted      (o_halted)
  );

  cpu_pc u_pc (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_inc    (pc_inc),
    .i_ld     (pc_ld),
    .i_target (target),
    .o_pc     (pc)
  );

  cpu_regfile u_regfile (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_rx_addr    (rx_addr),
    .i_ry_addr    (ry_addr),
    .i_write      (rf_write),
    .i_wb_sel     (wb_sel),
    .i_alu_result (alu_result),
    .i_mem_rdata  (i_mem_rdata),
    .o_rx_data    (rx_data),
    .o_ry_data    (ry_data)
  );

  cpu_alu u_alu (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_op      (alu_op),
    .i_imm_sel (alu_imm_sel),
    .i_flag_ld (flag_ld),
    .i_rx_data (rx_data),
    .i_ry_data (ry_data),
    .i_pc      (pc),
    .i_imm     (imm),
    .o_result  (alu_result),
    .o_target  (target),
    .o_flag_n  (flag_n),
    .o_flag_z  (flag_z)
  );

endmodule

`default_nettype wire

// ==== dv/cpu_top_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top_assert (
  input logic i_clk,
  input logic i_reset,
  input logic i_mem_rd,
  input logic i_mem_wr,
  input logic i_halted
);

  // one shared memory port
  a_rd_wr_exclusive: assert property (@(posedge i_clk) disable iff (i_reset)
    !(i_mem_rd && i_mem_wr))
    else $error("o_mem_rd and o_mem_wr are high together");

  a_halt_sticky: assert property (@(posedge i_clk) disable iff (i_reset)
    i_halted |=> i_halted)
    else $error("o_halted fell without a reset");

  a_quiet_when_halted: assert property (@(posedge i_clk) disable iff (i_reset)
    i_halted |-> !(i_mem_rd || i_mem_wr))
    else $error("memory strobe while halted");

  // asynchronous reset returns the controller to fetch
  a_reset_clears_halt: assert property (@(posedge i_clk) i_reset |-> !i_halted)
    else $error("o_halted high during reset");

endmodule

bind cpu_top cpu_top_assert u_assert (
  .i_clk    (i_clk),
  .i_reset  (i_reset),
  .i_mem_rd (o_mem_rd),
  .i_mem_wr (o_mem_wr),
  .i_halted (o_halted)
);

`default_nettype wire

// ==== dv/cpu_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top_tb;

  import cpu_isa_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 10;
  localparam int IDLE_CYCLES = 10;
  localparam int INSN_LIMIT = 200;
  localparam int NUM_TESTS = 8;
  // worst case of 4 cycles per instruction plus reset and idle per test
  localparam int WATCHDOG_NS =
    NUM_TESTS * (INSN_LIMIT * 4 + RESET_CYCLES + IDLE_CYCLES + 2) * CLK_PERIOD;

  logic        i_clk;
  logic        i_reset;
  word_t       mem_rdata;
  word_t       mem_addr;
  logic        mem_rd;
  logic        mem_wr;
  word_t       mem_wdata;
  logic        halted;

  word_t       mem [256];
  word_t       image [256];
  word_t       ref_mem [256];
  int          img_len;
  word_t       log_addr [$];
  word_t       log_data [$];
  word_t       exp_addr [$];
  word_t       exp_data [$];

  logic        rd_q;
  logic        wr_q;
  word_t       addr_q;
  word_t       wdata_q;
  logic [31:0] lcg_state;
  int          err_count;
  int          tests_run;
  int          tests_failed;
  logic        started;
  logic        halt_seen;
  int          cyc;
  int          halt_cycles;

  cpu_top i_cpu_top (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_mem_rdata (mem_rdata),
    .o_mem_addr  (mem_addr),
    .o_mem_rd    (mem_rd),
    .o_mem_wr    (mem_wr),
    .o_mem_wdata (mem_wdata),
    .o_halted    (halted)
  );

  initial i_clk = 1'b0;
  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  // memory strobes sampled mid cycle
  always @(negedge i_clk) begin
    rd_q = mem_rd;
    wr_q = mem_wr && !i_reset;
    addr_q = mem_addr;
    wdata_q = mem_wdata;
  end

  // read data valid in the cycle after the strobe
  always @(posedge i_clk) begin
    #1;
    if (rd_q) begin
      mem_rdata = mem[addr_q[7:0]];
    end
    if (wr_q) begin
      mem[addr_q[7:0]] = wdata_q;
      log_addr.push_back(addr_q);
      log_data.push_back(wdata_q);
    end
  end

  // reset behaviour, first fetch address, halt timing and quiet bus after halt
  always @(negedge i_clk) begin
    if (i_reset) begin
      assert (!mem_rd && !mem_wr && !halted) else begin
        $display("a strobe or o_halted is high while reset is asserted");
        err_count++;
      end
      started = 1'b0;
      halt_seen = 1'b0;
      cyc = 0;
    end else begin
      if (started && !halt_seen) begin
        cyc++;
      end
      if (!started && mem_rd) begin
        started = 1'b1;
        assert (mem_addr == 16'h0000) else begin
          $display("** Error: o_mem_addr at first fetch expected %h got %h", 16'h0000, mem_addr);
          err_count++;
        end
      end
      if (halted) begin
        if (!halt_seen) begin
          halt_cycles = cyc;
        end
        halt_seen = 1'b1;
        assert (!mem_rd && !mem_wr) else begin
          $display("a memory strobe appeared while the cpu is halted");
          err_count++;
        end
      end else begin
        assert (!halt_seen) else begin
          $display("o_halted dropped without a reset");
          err_count++;
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic word_t enc_r(input opcode_t op, input int rx, input int ry);
    logic [3:0] opc;
    opc = op;
    return {5'b0, ry[2:0], rx[2:0], 1'b0, opc};
  endfunction

  function automatic word_t enc_i(input opcode_t op, input int rx, input int imm);
    logic [3:0] opc;
    opc = op;
    return {imm[7:0], rx[2:0], 1'b1, opc};
  endfunction

  // instruction level model that fills the expected write list and returns the cycle count
  function automatic int ref_run(input int limit);
    word_t r [8];
    word_t pc;
    word_t ir;
    word_t imm;
    word_t b;
    word_t res;
    logic  fn;
    logic  fz;
    logic  done;
    int    cycles;
    for (int i = 0; i < 8; i++) begin
      r[i] = '0;
    end
    pc = '0;
    fn = 1'b0;
    fz = 1'b0;
    done = 1'b0;
    cycles = 0;
    exp_addr.delete();
    exp_data.delete();
    for (int n = 0; n < limit && !done; n++) begin
      ir = ref_mem[pc[7:0]];
      pc = pc + 16'd1;
      cycles += 3;
      imm = {{8{ir[15]}}, ir[15:8]};
      b = ir[4] ? imm : r[ir[10:8]];
      case (ir[3:0])
        op_mv: r[ir[7:5]] = b;
        op_add, op_sub, op_cmp: begin
          res = (ir[3:0] == op_add) ? r[ir[7:5]] + b : r[ir[7:5]] - b;
          fn = res[15];
          fz = (res == 16'd0);
          if (ir[3:0] != op_cmp) begin
            r[ir[7:5]] = res;
          end
        end
        op_ld: begin
          r[ir[7:5]] = ref_mem[r[ir[10:8]][7:0]];
          cycles += 1;
        end
        op_st: begin
          ref_mem[r[ir[10:8]][7:0]] = r[ir[7:5]];
          exp_addr.push_back(r[ir[10:8]]);
          exp_data.push_back(r[ir[7:5]]);
        end
        op_j, op_jz, op_jn: begin
          if (ir[3:0] == op_j || (ir[3:0] == op_jz && fz) || (ir[3:0] == op_jn && fn)) begin
            pc = ir[4] ? pc + imm : r[ir[7:5]];
          end
        end
        op_halt: done = 1'b1;
        default: ;
      endcase
    end
    return cycles;
  endfunction

  task automatic emit(input word_t w);
    image[img_len] = w;
    img_len++;
  endtask

  task automatic clear_image();
    for (int a = 0; a < 256; a++) begin
      image[a] = {a[7:0] ^ 8'h5a, ~a[7:0]};
    end
    img_len = 0;
  endtask

  task automatic run_test(input string name);
    int   err_start;
    int   exp_cycles;
    logic got_halt;
    err_start = err_count;
    got_halt = 1'b0;
    for (int a = 0; a < 256; a++) begin
      ref_mem[a] = image[a];
    end
    exp_cycles = ref_run(INSN_LIMIT);
    @(posedge i_clk);
    #1;
    i_reset = 1'b1;
    for (int a = 0; a < 256; a++) begin
      mem[a] = image[a];
    end
    log_addr.delete();
    log_data.delete();
    repeat (RESET_CYCLES) @(posedge i_clk);
    #1;
    i_reset = 1'b0;
    for (int c = 0; c < INSN_LIMIT * 4 && !got_halt; c++) begin
      @(negedge i_clk);
      got_halt = halted;
    end
    repeat (IDLE_CYCLES) @(negedge i_clk);
    assert (got_halt) else begin
      $display("%s: o_halted never rose within %0d cycles", name, INSN_LIMIT * 4);
      err_count++;
    end
    assert (!got_halt || halt_cycles == exp_cycles) else begin
      $display("** Error: %s halt_cycles expected %h got %h", name, exp_cycles, halt_cycles);
      err_count++;
    end
    assert (log_addr.size() == exp_addr.size()) else begin
      $display("%s: the DUT made %0d writes where %0d were expected",
               name, log_addr.size(), exp_addr.size());
      err_count++;
    end
    for (int i = 0; i < log_addr.size() && i < exp_addr.size(); i++) begin
      assert (log_addr[i] == exp_addr[i]) else begin
        $display("** Error: %s write %0d o_mem_addr expected %h got %h",
                 name, i, exp_addr[i], log_addr[i]);
        err_count++;
      end
      assert (log_data[i] == exp_data[i]) else begin
        $display("** Error: %s write %0d o_mem_wdata expected %h got %h",
                 name, i, exp_data[i], log_data[i]);
        err_count++;
      end
    end
    tests_run++;
    if (err_count != err_start) begin
      tests_failed++;
    end
    $display("test %0d %-8s %s  writes %0d  cycles %0d", tests_run, name,
             (err_count == err_start) ? "pass" : "FAIL", log_addr.size(), halt_cycles);
  endtask

  // jump over one marker move; the stored marker shows the path taken
  task automatic probe(input opcode_t jop, input logic jreg, input logic cimm,
                       input int cx, input int cy);
    int base;
    base = img_len;
    emit(enc_i(op_mv, 4, 0));
    emit(enc_i(op_mv, 5, base + 5));
    emit(cimm ? enc_i(op_cmp, cx, cy) : enc_r(op_cmp, cx, cy));
    emit(jreg ? enc_r(jop, 5, 0) : enc_i(jop, 0, 1));
    emit(enc_i(op_mv, 4, base + 16));
    emit(enc_r(op_st, 4, 7));
    emit(enc_i(op_add, 7, 1));
  endtask

  task automatic build_arith();
    clear_image();
    emit(enc_i(op_mv, 1, 100));
    emit(enc_i(op_mv, 2, -3));
    emit(enc_r(op_mv, 3, 1));
    emit(enc_r(op_add, 3, 2));
    emit(enc_i(op_add, 1, 127));
    emit(enc_r(op_sub, 2, 1));
    emit(enc_i(op_sub, 3, -128));
    emit(enc_i(op_mv, 5, -1));
    emit(enc_i(op_add, 5, 1));
    emit(enc_i(op_mv, 4, -1));
    emit(enc_r(op_add, 4, 1));
    emit(enc_r(op_sub, 0, 1));
    emit(enc_i(op_mv, 7, 8'h70));
    for (int k = 0; k < 7; k++) begin
      emit(enc_r(op_st, k, 7));
      emit(enc_i(op_add, 7, 1));
    end
    emit(enc_r(op_halt, 0, 0));
  endtask

  task automatic build_branch();
    clear_image();
    emit(enc_i(op_mv, 1, 5));
    emit(enc_i(op_mv, 2, 5));
    emit(enc_i(op_mv, 3, 9));
    emit(enc_i(op_mv, 7, 8'h70));
    probe(op_jz, 1'b0, 1'b0, 1, 2);
    probe(op_jz, 1'b1, 1'b1, 1, 5);
    probe(op_jz, 1'b0, 1'b1, 1, 3);
    probe(op_jz, 1'b1, 1'b0, 3, 1);
    probe(op_jn, 1'b0, 1'b0, 1, 3);
    probe(op_jn, 1'b1, 1'b1, 3, 2);
    probe(op_jn, 1'b1, 1'b0, 1, 3);
    probe(op_jn, 1'b0, 1'b1, 1, -7);
    probe(op_j, 1'b0, 1'b0, 1, 1);
    probe(op_j, 1'b1, 1'b0, 1, 1);
    // count down loop with a backward jump
    emit(enc_i(op_mv, 1, 3));
    emit(enc_r(op_st, 1, 7));
    emit(enc_i(op_add, 7, 1));
    emit(enc_i(op_sub, 1, 1));
    emit(enc_i(op_jz, 0, 1));
    emit(enc_i(op_j, 0, -5));
    emit(enc_r(op_halt, 0, 0));
  endtask

  task automatic build_ldst();
    clear_image();
    emit(enc_i(op_mv, 7, 8'h60));
    emit(enc_i(op_mv, 1, 8'h2a));
    emit(enc_r(op_st, 1, 7));
    emit(enc_i(op_add, 7, 3));
    emit(enc_i(op_mv, 2, -100));
    emit(enc_r(op_st, 2, 7));
    emit(enc_i(op_mv, 3, 8'h60));
    emit(enc_r(op_ld, 4, 3));
    emit(enc_i(op_add, 3, 3));
    emit(enc_r(op_ld, 5, 3));
    emit(enc_i(op_mv, 6, 8'h50));
    emit(enc_r(op_st, 4, 6));
    emit(enc_i(op_add, 6, 1));
    emit(enc_r(op_st, 5, 6));
    emit(enc_i(op_add, 6, 1));
    emit(enc_i(op_mv, 3, 8'h7e));
    emit(enc_r(op_ld, 3, 3));
    emit(enc_r(op_st, 3, 6));
    emit(enc_r(op_halt, 0, 0));
  endtask

  task automatic build_random(input int n);
    logic [31:0] r;
    int          rx;
    int          ry;
    int          imm;
    clear_image();
    for (int k = 0; k < 7; k++) begin
      r = lcg_next();
      emit(enc_i(op_mv, k, r[31:24]));
    end
    emit(enc_i(op_mv, 7, 8'h70));
    for (int k = 0; k < n; k++) begin
      r = lcg_next();
      // r7 holds the store pointer
      rx = (r[22:20] == 3'd7) ? 6 : r[22:20];
      ry = r[26:24];
      imm = r[31:24];
      case (r[18:16])
        3'd0: emit(enc_r(op_mv, rx, ry));
        3'd1: emit(enc_i(op_mv, rx, imm));
        3'd2: emit(enc_r(op_add, rx, ry));
        3'd3: emit(enc_i(op_add, rx, imm));
        3'd4: emit(enc_r(op_sub, rx, ry));
        3'd5: emit(enc_i(op_sub, rx, imm));
        3'd6: emit(r[23] ? enc_i(op_cmp, rx, imm) : enc_r(op_cmp, rx, ry));
        default: begin
          emit(enc_r(op_st, rx, 7));
          emit(enc_i(op_add, 7, 1));
        end
      endcase
    end
    // final register values go out to memory
    for (int k = 0; k < 7; k++) begin
      emit(enc_r(op_st, k, 7));
      emit(enc_i(op_add, 7, 1));
    end
    emit(enc_r(op_halt, 0, 0));
  endtask

  task automatic build_halt();
    clear_image();
    emit(enc_i(op_mv, 3, 8'h40));
    emit(enc_r(op_ld, 1, 3));
    emit(16'h0006);
    emit(enc_i(op_ld, 2, 3));
    emit(16'h001c);
    emit(enc_r(op_st, 1, 0));
    emit(enc_i(op_halt, 0, 0));
    // never reached
    emit(enc_r(op_st, 2, 3));
  endtask

  initial begin
    i_reset = 1'b1;
    mem_rdata = '0;
    err_count = 0;
    tests_run = 0;
    tests_failed = 0;
    lcg_state = 32'h99c9;
    started = 1'b0;
    halt_seen = 1'b0;
    cyc = 0;
    halt_cycles = 0;
    img_len = 0;

    clear_image();
    emit(enc_i(op_mv, 1, 8'h33));
    emit(enc_r(op_st, 1, 0));
    emit(enc_r(op_halt, 0, 0));
    run_test("reset");
    build_arith();
    run_test("arith");
    build_branch();
    run_test("branch");
    build_ldst();
    run_test("ldst");
    for (int k = 0; k < 3; k++) begin
      build_random(40);
      run_test("random");
    end
    build_halt();
    run_test("halt");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== cpu_top.f ====
src/cpu_isa_pkg.sv
src/cpu_ctrl_pkg.sv
src/cpu_control.sv
src/cpu_pc.sv
src/cpu_regfile.sv
src/cpu_alu.sv
src/cpu_top.sv
dv/cpu_top_assert.sv
dv/cpu_top_tb.sv
